// File: verilog/bridgePkg.sv
/* Read-channel bridge shared definitions */
package bridgePkg;

    // AXI read channel field widths
    localparam int idW    = 4;
    localparam int addrW  = 32;
    localparam int lenW   = 4;
    localparam int sizeW  = 3;
    localparam int burstW = 2;
    localparam int dataW  = 32;
    localparam int respW  = 2;

    // Packed word widths, fields only
    localparam int arWordW = idW + addrW + lenW + sizeW + burstW;
    localparam int rWordW  = idW + dataW + respW + 1;

    // Async FIFO geometry
    localparam int fifoAddrW = 4;
    localparam int fifoDepth = 1 << fifoAddrW;

    // Field types
    typedef logic [idW-1:0]    axiId_t;
    typedef logic [addrW-1:0]  axiAddr_t;
    typedef logic [lenW-1:0]   axiLen_t;
    typedef logic [sizeW-1:0]  axiSize_t;
    typedef logic [burstW-1:0] axiBurst_t;
    typedef logic [dataW-1:0]  axiData_t;
    typedef logic [respW-1:0]  axiResp_t;

    // FIFO pointer with one extra wrap bit
    typedef logic [fifoAddrW:0] fifoPtr_t;

endpackage

// File: verilog/fifoWriteSide.sv
/* Async FIFO write side */
`timescale 1ns/1ns

module fifoWriteSide #(
    parameter int wordW = 8
) (
    input  logic                           wrClk_i,
    input  logic                           arstN_i,
    // Write port
    input  logic [wordW-1:0]               wrWord_i,
    input  logic                           wrEn_i,
    output logic                           full_o,
    // From the read side
    input  bridgePkg::fifoPtr_t            rdPtrGray_i,
    input  logic [bridgePkg::fifoAddrW-1:0] rdAddr_i,
    // To the read side
    output bridgePkg::fifoPtr_t            wrPtrGray_o,
    output logic [wordW-1:0]               rdWord_o
);

    localparam int aw = bridgePkg::fifoAddrW;

    // Word storage
    logic [wordW-1:0] mem [bridgePkg::fifoDepth];

    bridgePkg::fifoPtr_t wrPtrBin;
    bridgePkg::fifoPtr_t wrPtrGray;
    bridgePkg::fifoPtr_t wrPtrBinNext;
    bridgePkg::fifoPtr_t wrPtrGrayNext;

    // Two-flop synchroniser for the read pointer
    bridgePkg::fifoPtr_t rdPtrGrayMeta;
    bridgePkg::fifoPtr_t rdPtrGraySync;

    logic wrAccept;

    assign wrAccept      = wrEn_i && !full_o;
    assign wrPtrBinNext  = wrPtrBin + bridgePkg::fifoPtr_t'(wrAccept);
    assign wrPtrGrayNext = wrPtrBinNext ^ (wrPtrBinNext >> 1);

    always_ff @(posedge wrClk_i) begin
        if (wrAccept) begin
            mem[wrPtrBin[aw-1:0]] <= wrWord_i;
        end
    end

    // Write pointer in binary and Gray
    always_ff @(posedge wrClk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtrBin  <= '0;
            wrPtrGray <= '0;
        end else begin
            wrPtrBin  <= wrPtrBinNext;
            wrPtrGray <= wrPtrGrayNext;
        end
    end

    always_ff @(posedge wrClk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            rdPtrGrayMeta <= '0;
            rdPtrGraySync <= '0;
        end else begin
            rdPtrGrayMeta <= rdPtrGray_i;
            rdPtrGraySync <= rdPtrGrayMeta;
        end
    end

    // Full when the pointers differ only in the top two Gray bits
    assign full_o = (wrPtrGray == {~rdPtrGraySync[aw:aw-1], rdPtrGraySync[aw-2:0]});

    assign wrPtrGray_o = wrPtrGray;

    // Read side picks its word straight from storage
    assign rdWord_o = mem[rdAddr_i];

    function automatic bridgePkg::fifoPtr_t grayToBin(input bridgePkg::fifoPtr_t gray);
        bridgePkg::fifoPtr_t bin;
        bin[aw] = gray[aw];
        for (int i = aw - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Write pointer never runs more than one full FIFO ahead of the read pointer
    assert property (@(posedge wrClk_i) disable iff (!arstN_i)
        bridgePkg::fifoPtr_t'(wrPtrBin - grayToBin(rdPtrGraySync)) <= bridgePkg::fifoDepth)
        else $error("write pointer ran past a full FIFO");

endmodule

// File: verilog/fifoReadSide.sv
/* Async FIFO read side */
`timescale 1ns/1ns

module fifoReadSide (
    input  logic                            rdClk_i,
    input  logic                            arstN_i,
    // Read port
    input  logic                            rdEn_i,
    output logic                            empty_o,
    // From the write side
    input  bridgePkg::fifoPtr_t             wrPtrGray_i,
    // To the write side
    output bridgePkg::fifoPtr_t             rdPtrGray_o,
    output logic [bridgePkg::fifoAddrW-1:0] rdAddr_o
);

    localparam int aw = bridgePkg::fifoAddrW;

    bridgePkg::fifoPtr_t rdPtrBin;
    bridgePkg::fifoPtr_t rdPtrGray;
    bridgePkg::fifoPtr_t rdPtrBinNext;
    bridgePkg::fifoPtr_t rdPtrGrayNext;

    // Write pointer after two read-clock flops
    bridgePkg::fifoPtr_t wrPtrGrayMeta;
    bridgePkg::fifoPtr_t wrPtrGraySync;

    logic rdAccept;

    assign rdAccept      = rdEn_i && !empty_o;
    assign rdPtrBinNext  = rdPtrBin + bridgePkg::fifoPtr_t'(rdAccept);
    assign rdPtrGrayNext = rdPtrBinNext ^ (rdPtrBinNext >> 1);

    always_ff @(posedge rdClk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            rdPtrBin  <= '0;
            rdPtrGray <= '0;
        end else begin
            rdPtrBin  <= rdPtrBinNext;
            rdPtrGray <= rdPtrGrayNext;
        end
    end

    always_ff @(posedge rdClk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtrGrayMeta <= '0;
            wrPtrGraySync <= '0;
        end else begin
            wrPtrGrayMeta <= wrPtrGray_i;
            wrPtrGraySync <= wrPtrGrayMeta;
        end
    end

    // Empty while the synchronised write pointer has not moved past us
    assign empty_o = (rdPtrGray == wrPtrGraySync);

    assign rdPtrGray_o = rdPtrGray;
    assign rdAddr_o    = rdPtrBin[aw-1:0];

    function automatic bridgePkg::fifoPtr_t grayToBin(input bridgePkg::fifoPtr_t gray);
        bridgePkg::fifoPtr_t bin;
        bin[aw] = gray[aw];
        for (int i = aw - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Read pointer never overtakes the synchronised write pointer
    assert property (@(posedge rdClk_i) disable iff (!arstN_i)
        bridgePkg::fifoPtr_t'(grayToBin(wrPtrGraySync) - rdPtrBin) <= bridgePkg::fifoDepth)
        else $error("read pointer ran past the write pointer");

endmodule

// File: verilog/readChannelBridge.sv
/* AXI read channel clock-domain bridge */
`timescale 1ns/1ns

module readChannelBridge (
    input  logic                  CPU_CLK_i,
    input  logic                  AXI_CLK_i,
    input  logic                  arstN_i,
    // CPU side, read address
    input  bridgePkg::axiId_t     arId_i,
    input  bridgePkg::axiAddr_t   arAddr_i,
    input  bridgePkg::axiLen_t    arLen_i,
    input  bridgePkg::axiSize_t   arSize_i,
    input  bridgePkg::axiBurst_t  arBurst_i,
    input  logic                  arValid_i,
    output logic                  arReady_o,
    // CPU side, read data
    output bridgePkg::axiId_t     rId_o,
    output bridgePkg::axiData_t   rData_o,
    output bridgePkg::axiResp_t   rResp_o,
    output logic                  rLast_o,
    output logic                  rValid_o,
    input  logic                  rReady_i,
    // AXI side, read address
    output bridgePkg::axiId_t     busArId_o,
    output bridgePkg::axiAddr_t   busArAddr_o,
    output bridgePkg::axiLen_t    busArLen_o,
    output bridgePkg::axiSize_t   busArSize_o,
    output bridgePkg::axiBurst_t  busArBurst_o,
    output logic                  busArValid_o,
    input  logic                  busArReady_i,
    // AXI side, read data
    input  bridgePkg::axiId_t     busRId_i,
    input  bridgePkg::axiData_t   busRData_i,
    input  bridgePkg::axiResp_t   busRResp_i,
    input  logic                  busRLast_i,
    input  logic                  busRValid_i,
    output logic                  busRReady_o
);

    // AR FIFO, CPU clock in, AXI clock out
    logic [bridgePkg::arWordW-1:0]   arWrWord;
    logic [bridgePkg::arWordW-1:0]   arRdWord;
    bridgePkg::fifoPtr_t             arWrPtrGray;
    bridgePkg::fifoPtr_t             arRdPtrGray;
    logic [bridgePkg::fifoAddrW-1:0] arRdAddr;
    logic                            arFull;
    logic                            arEmpty;

    // R FIFO, AXI clock in, CPU clock out
    logic [bridgePkg::rWordW-1:0]    rWrWord;
    logic [bridgePkg::rWordW-1:0]    rRdWord;
    bridgePkg::fifoPtr_t             rWrPtrGray;
    bridgePkg::fifoPtr_t             rRdPtrGray;
    logic [bridgePkg::fifoAddrW-1:0] rRdAddr;
    logic                            rFull;
    logic                            rEmpty;

    assign arWrWord = {arId_i, arAddr_i, arLen_i, arSize_i, arBurst_i};
    assign {busArId_o, busArAddr_o, busArLen_o, busArSize_o, busArBurst_o} = arRdWord;
    assign arReady_o    = ~arFull;
    assign busArValid_o = ~arEmpty;

    assign rWrWord = {busRId_i, busRData_i, busRResp_i, busRLast_i};
    assign {rId_o, rData_o, rResp_o, rLast_o} = rRdWord;
    assign busRReady_o = ~rFull;
    assign rValid_o    = ~rEmpty;

    fifoWriteSide #(
        .wordW(bridgePkg::arWordW)
    ) arWrite (
        .wrClk_i     (CPU_CLK_i),
        .arstN_i     (arstN_i),
        .wrWord_i    (arWrWord),
        .wrEn_i      (arValid_i),
        .full_o      (arFull),
        .rdPtrGray_i (arRdPtrGray),
        .rdAddr_i    (arRdAddr),
        .wrPtrGray_o (arWrPtrGray),
        .rdWord_o    (arRdWord)
    );

    fifoReadSide arRead (
        .rdClk_i     (AXI_CLK_i),
        .arstN_i     (arstN_i),
        .rdEn_i      (busArReady_i),
        .empty_o     (arEmpty),
        .wrPtrGray_i (arWrPtrGray),
        .rdPtrGray_o (arRdPtrGray),
        .rdAddr_o    (arRdAddr)
    );

    fifoWriteSide #(
        .wordW(bridgePkg::rWordW)
    ) rWrite (
        .wrClk_i     (AXI_CLK_i),
        .arstN_i     (arstN_i),
        .wrWord_i    (rWrWord),
        .wrEn_i      (busRValid_i),
        .full_o      (rFull),
        .rdPtrGray_i (rRdPtrGray),
        .rdAddr_i    (rRdAddr),
        .wrPtrGray_o (rWrPtrGray),
        .rdWord_o    (rRdWord)
    );

    fifoReadSide rRead (
        .rdClk_i     (CPU_CLK_i),
        .arstN_i     (arstN_i),
        .rdEn_i      (rReady_i),
        .empty_o     (rEmpty),
        .wrPtrGray_i (rWrPtrGray),
        .rdPtrGray_o (rRdPtrGray),
        .rdAddr_o    (rRdAddr)
    );

endmodule

// File: testbench/tbReadChannelBridge.sv
/* Read-channel bridge testbench */
`timescale 1ns/1ns

module tbReadChannelBridge;

    localparam int cpuHalf = 2;
    localparam int axiHalf = 3;
    localparam int numXfers = 300;
    // Rough run length in CPU cycles, timeout at ten times that
    localparam int estCycles = 6 * numXfers + 8 * bridgePkg::fifoDepth + 72;
    localparam int timeoutCycles = 10 * estCycles;

    logic CPU_CLK_i;
    logic AXI_CLK_i;
    logic arstN_i;

    bridgePkg::axiId_t    arId_i;
    bridgePkg::axiAddr_t  arAddr_i;
    bridgePkg::axiLen_t   arLen_i;
    bridgePkg::axiSize_t  arSize_i;
    bridgePkg::axiBurst_t arBurst_i;
    logic                 arValid_i;
    logic                 arReady_o;
    bridgePkg::axiId_t    rId_o;
    bridgePkg::axiData_t  rData_o;
    bridgePkg::axiResp_t  rResp_o;
    logic                 rLast_o;
    logic                 rValid_o;
    logic                 rReady_i;
    bridgePkg::axiId_t    busArId_o;
    bridgePkg::axiAddr_t  busArAddr_o;
    bridgePkg::axiLen_t   busArLen_o;
    bridgePkg::axiSize_t  busArSize_o;
    bridgePkg::axiBurst_t busArBurst_o;
    logic                 busArValid_o;
    logic                 busArReady_i;
    bridgePkg::axiId_t    busRId_i;
    bridgePkg::axiData_t  busRData_i;
    bridgePkg::axiResp_t  busRResp_i;
    logic                 busRLast_i;
    logic                 busRValid_i;
    logic                 busRReady_o;

    // Reference queues, one packed word per accepted transfer
    logic [bridgePkg::arWordW-1:0] arQ[$];
    logic [bridgePkg::rWordW-1:0]  rQ[$];

    integer seed = 79358;
    int cycleCount = 0;

    readChannelBridge uut (.*);

    initial begin
        CPU_CLK_i = 1'b0;
        forever #cpuHalf CPU_CLK_i = ~CPU_CLK_i;
    end

    initial begin
        AXI_CLK_i = 1'b0;
        forever #axiHalf AXI_CLK_i = ~AXI_CLK_i;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkEqual(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
        end
    endtask

    always @(posedge CPU_CLK_i) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            failRun($sformatf("Run timed out after %0d CPU cycles", cycleCount));
        end
    end

    // CPU side AR producer, a push marks the transfer at the next rising edge
    task automatic sendAr(input int count, input bit alwaysValid);
        int sent;
        logic [31:0] rnd;
        sent = 0;
        while (sent < count) begin
            @(negedge CPU_CLK_i);
            rnd = $random(seed);
            arAddr_i = rnd;
            rnd = $random(seed);
            arId_i    = rnd[3:0];
            arLen_i   = rnd[7:4];
            arSize_i  = rnd[10:8];
            arBurst_i = rnd[12:11];
            arValid_i = alwaysValid | (rnd[14:13] != 2'b00);
            if (arValid_i && arReady_o) begin
                arQ.push_back({arId_i, arAddr_i, arLen_i, arSize_i, arBurst_i});
                sent++;
            end
        end
        @(negedge CPU_CLK_i);
        arValid_i = 1'b0;
    endtask

    // Bus side AR consumer
    task automatic recvAr(input int count, input bit alwaysReady);
        int got;
        logic [31:0] rnd;
        bridgePkg::axiId_t    eId;
        bridgePkg::axiAddr_t  eAddr;
        bridgePkg::axiLen_t   eLen;
        bridgePkg::axiSize_t  eSize;
        bridgePkg::axiBurst_t eBurst;
        got = 0;
        while (got < count) begin
            @(negedge AXI_CLK_i);
            rnd = $random(seed);
            busArReady_i = alwaysReady | rnd[0];
            if (busArReady_i && busArValid_o) begin
                if (arQ.size() == 0) begin
                    failRun("AR valid was high at a handshake with no word outstanding");
                end else begin
                    {eId, eAddr, eLen, eSize, eBurst} = arQ.pop_front();
                    checkEqual("busArId_o", 64'(busArId_o), 64'(eId));
                    checkEqual("busArAddr_o", 64'(busArAddr_o), 64'(eAddr));
                    checkEqual("busArLen_o", 64'(busArLen_o), 64'(eLen));
                    checkEqual("busArSize_o", 64'(busArSize_o), 64'(eSize));
                    checkEqual("busArBurst_o", 64'(busArBurst_o), 64'(eBurst));
                    got++;
                end
            end
        end
        @(negedge AXI_CLK_i);
        busArReady_i = 1'b0;
    endtask

    // Bus side R producer
    task automatic sendR(input int count);
        int sent;
        logic [31:0] rnd;
        sent = 0;
        while (sent < count) begin
            @(negedge AXI_CLK_i);
            rnd = $random(seed);
            busRData_i = rnd;
            rnd = $random(seed);
            busRId_i    = rnd[3:0];
            busRResp_i  = rnd[5:4];
            busRLast_i  = rnd[6];
            busRValid_i = (rnd[9:8] != 2'b00);
            if (busRValid_i && busRReady_o) begin
                rQ.push_back({busRId_i, busRData_i, busRResp_i, busRLast_i});
                sent++;
            end
        end
        @(negedge AXI_CLK_i);
        busRValid_i = 1'b0;
    endtask

    // CPU side R consumer
    task automatic recvR(input int count);
        int got;
        logic [31:0] rnd;
        bridgePkg::axiId_t   eId;
        bridgePkg::axiData_t eData;
        bridgePkg::axiResp_t eResp;
        logic                eLast;
        got = 0;
        while (got < count) begin
            @(negedge CPU_CLK_i);
            rnd = $random(seed);
            rReady_i = rnd[0];
            if (rReady_i && rValid_o) begin
                if (rQ.size() == 0) begin
                    failRun("R valid was high at a handshake with no word outstanding");
                end else begin
                    {eId, eData, eResp, eLast} = rQ.pop_front();
                    checkEqual("rId_o", 64'(rId_o), 64'(eId));
                    checkEqual("rData_o", 64'(rData_o), 64'(eData));
                    checkEqual("rResp_o", 64'(rResp_o), 64'(eResp));
                    checkEqual("rLast_o", 64'(rLast_o), 64'(eLast));
                    got++;
                end
            end
        end
        @(negedge CPU_CLK_i);
        rReady_i = 1'b0;
    endtask

    initial begin
        arstN_i      = 1'b0;
        arId_i       = '0;
        arAddr_i     = '0;
        arLen_i      = '0;
        arSize_i     = '0;
        arBurst_i    = '0;
        arValid_i    = 1'b0;
        rReady_i     = 1'b0;
        busArReady_i = 1'b0;
        busRId_i     = '0;
        busRData_i   = '0;
        busRResp_i   = '0;
        busRLast_i   = 1'b0;
        busRValid_i  = 1'b0;

        // Release between edges of both clocks
        repeat (10) @(posedge CPU_CLK_i);
        @(negedge CPU_CLK_i);
        #1;
        arstN_i = 1'b1;

        @(negedge CPU_CLK_i);
        checkEqual("arReady_o", 64'(arReady_o), 64'd1);
        checkEqual("busRReady_o", 64'(busRReady_o), 64'd1);
        checkEqual("busArValid_o", 64'(busArValid_o), 64'd0);
        checkEqual("rValid_o", 64'(rValid_o), 64'd0);

        // Random traffic on both channels at once
        fork
            sendAr(numXfers, 1'b0);
            recvAr(numXfers, 1'b0);
            sendR(numXfers);
            recvR(numXfers);
        join
        checkEqual("arQ size", 64'(arQ.size()), 64'd0);
        checkEqual("rQ size", 64'(rQ.size()), 64'd0);

        // Fill the AR FIFO with the bus side stalled
        sendAr(bridgePkg::fifoDepth, 1'b1);
        repeat (24) begin
            @(negedge CPU_CLK_i);
            arValid_i = 1'b1;
            checkEqual("arReady_o", 64'(arReady_o), 64'd0);
        end
        @(negedge CPU_CLK_i);
        arValid_i = 1'b0;

        // Drain in order, then ready comes back
        recvAr(bridgePkg::fifoDepth, 1'b1);
        checkEqual("arQ size", 64'(arQ.size()), 64'd0);
        @(negedge CPU_CLK_i);
        while (arReady_o !== 1'b1) begin
            @(negedge CPU_CLK_i);
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: project.f
verilog/bridgePkg.sv
verilog/fifoWriteSide.sv
verilog/fifoReadSide.sv
verilog/readChannelBridge.sv
testbench/tbReadChannelBridge.sv

// File: Makefile
SRCS := $(wildcard verilog/*.sv testbench/*.sv)
BIN  := obj_dir/VtbReadChannelBridge

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tbReadChannelBridge -f project.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "test failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
